// File: hdl/modefind_consts.svh
`ifndef MODEFIND_CONSTS_SVH
`define MODEFIND_CONSTS_SVH

// FP16 word width
`define MF_FP_W 16

// Exponent bins in the histogram
`define MF_BINS 8

// Bin, sample and job-size counters
`define MF_CNT_W 8

// Biased exponent that lands in bin 0, so 2^-2 and below
`define MF_BIN_EXP_BASE 13

`endif

// File: hdl/modefind_pkg.sv
`default_nettype none
`include "modefind_consts.svh"

package modefind_pkg;

  //////////////////////////////////////////////////////////////////////
  // FP16 word
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       sign;
    logic [4:0] exp;
    logic [9:0] man;
  } fp16_fields_t;

  // Raw bits for moves and sign flips, fields for the arithmetic
  typedef union packed {
    logic [`MF_FP_W-1:0] bits;
    fp16_fields_t        f;
  } fp16_t;

  //////////////////////////////////////////////////////////////////////
  // Lane and histogram bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    fp16_t s;
    fp16_t a_acc;
    fp16_t a_pos;
    fp16_t b_acc;
    fp16_t b_pos;
  } lane_in_t;

  // Bin is one-hot over the exponent bins
  typedef struct packed {
    fp16_t               alpha;
    fp16_t               alpha_scaled;
    fp16_t               beta;
    logic [`MF_BINS-1:0] bin;
  } lane_res_t;

  typedef struct packed {
    logic [$clog2(`MF_BINS)-1:0] mode_bin;
    logic [`MF_CNT_W-1:0]        mode_cnt;
    logic                        finished;
  } hist_stat_t;

endpackage

`default_nettype wire

// File: hdl/fp16_add.sv
`default_nettype none

module fp16_add (
  input  modefind_pkg::fp16_t a_i,
  input  modefind_pkg::fp16_t b_i,
  output modefind_pkg::fp16_t sum_o
);

  localparam int MAN_W = 10;
  // Working mantissa, hidden bit on top and 13 spare bits below
  localparam int EXT_W = 24;
  localparam int PAD_W = EXT_W - MAN_W - 1;

  modefind_pkg::fp16_t   op_big;
  modefind_pkg::fp16_t   op_small;
  logic [EXT_W-1:0]      big_m;
  logic [EXT_W-1:0]      small_m;
  logic [EXT_W-1:0]      small_sh;
  logic [4:0]            exp_diff;
  logic                  lost;
  logic [EXT_W:0]        raw;
  logic [EXT_W:0]        norm;
  logic [4:0]            lz;
  logic signed [6:0]     res_exp;

  //////////////////////////////////////////////////////////////////////
  // Operand ordering and alignment
  //////////////////////////////////////////////////////////////////////

  // Larger magnitude first, so the subtraction never goes negative
  always_comb begin
    if ({a_i.f.exp, a_i.f.man} >= {b_i.f.exp, b_i.f.man}) begin
      op_big   = a_i;
      op_small = b_i;
    end else begin
      op_big   = b_i;
      op_small = a_i;
    end
  end

  // Subnormals count as zero
  assign big_m   = (op_big.f.exp == 5'd0) ? '0 :
                   {1'b1, op_big.f.man, {PAD_W{1'b0}}};
  assign small_m = (op_small.f.exp == 5'd0) ? '0 :
                   {1'b1, op_small.f.man, {PAD_W{1'b0}}};

  assign exp_diff = op_big.f.exp - op_small.f.exp;
  assign small_sh = small_m >> exp_diff;

  // Sticky bit keeps a far-off subtrahend from vanishing
  assign lost = (small_sh << exp_diff) != small_m;

  always_comb begin
    if (op_big.f.sign == op_small.f.sign) begin
      raw = {1'b0, big_m} + {1'b0, small_sh | EXT_W'(lost)};
    end else begin
      raw = {1'b0, big_m} - {1'b0, small_sh | EXT_W'(lost)};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Normalisation
  //////////////////////////////////////////////////////////////////////

  // Leading zero count over the raw sum, highest one wins
  always_comb begin
    lz = 5'd0;
    for (int i = 0; i <= EXT_W; i++) begin
      if (raw[i]) begin
        lz = 5'(EXT_W - i);
      end
    end
  end

  assign norm    = raw << lz;
  assign res_exp = $signed({2'b00, op_big.f.exp}) + 7'sd1 - $signed({2'b00, lz});

  // Dropped bits below the mantissa give truncation toward zero
  always_comb begin
    if (raw == '0 || res_exp <= 7'sd0) begin
      sum_o.bits = '0;
    end else if (res_exp >= 7'sd31) begin
      sum_o.bits = {op_big.f.sign, 5'h1e, {MAN_W{1'b1}}};
    end else begin
      sum_o.bits = {op_big.f.sign, res_exp[4:0], norm[EXT_W-1 -: MAN_W]};
    end
  end

endmodule

`default_nettype wire

// File: hdl/fp16_mul.sv
`default_nettype none

module fp16_mul (
  input  modefind_pkg::fp16_t a_i,
  input  modefind_pkg::fp16_t b_i,
  output modefind_pkg::fp16_t prod_o
);

  localparam int MAN_W = 10;
  localparam int BIAS  = 15;

  logic [MAN_W:0]       ma;
  logic [MAN_W:0]       mb;
  logic [2*MAN_W+1:0]   prod;
  logic signed [6:0]    exp_sum;
  logic signed [6:0]    res_exp;
  logic [MAN_W-1:0]     res_man;
  logic                 res_sign;
  logic                 in_zero;

  // Zero and subnormal inputs both flush
  assign in_zero = (a_i.f.exp == 5'd0) || (b_i.f.exp == 5'd0);

  assign ma       = {1'b1, a_i.f.man};
  assign mb       = {1'b1, b_i.f.man};
  assign prod     = ma * mb;
  assign res_sign = a_i.f.sign ^ b_i.f.sign;

  assign exp_sum = $signed({2'b00, a_i.f.exp}) + $signed({2'b00, b_i.f.exp}) - 7'(BIAS);

  // Product of two 1.x values lies in [1,4), one shift at most
  always_comb begin
    if (prod[2*MAN_W+1]) begin
      res_exp = exp_sum + 7'sd1;
      res_man = prod[2*MAN_W -: MAN_W];
    end else begin
      res_exp = exp_sum;
      res_man = prod[2*MAN_W-1 -: MAN_W];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Flush and saturate
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (in_zero || res_exp <= 7'sd0) begin
      prod_o.bits = '0;
    end else if (res_exp >= 7'sd31) begin
      // Largest finite value, sign kept
      prod_o.bits = {res_sign, 5'h1e, {MAN_W{1'b1}}};
    end else begin
      prod_o.bits = {res_sign, res_exp[4:0], res_man};
    end
  end

endmodule

`default_nettype wire

// File: hdl/modefind_lane.sv
`default_nettype none
`include "modefind_consts.svh"

module modefind_lane (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    valid_i,
  input  modefind_pkg::lane_in_t  smp_i,
  output modefind_pkg::lane_res_t res_o,
  output logic                    res_valid_o
);

  localparam int IDX_W = $clog2(`MF_BINS);

  modefind_pkg::fp16_t neg_a_pos;
  modefind_pkg::fp16_t neg_b_pos;
  modefind_pkg::fp16_t alpha;
  modefind_pkg::fp16_t beta;
  modefind_pkg::fp16_t alpha_scaled;
  logic [4:0]          exp_ofs;
  logic [IDX_W-1:0]    bin_idx;
  logic [`MF_BINS-1:0] bin_hot;

  //////////////////////////////////////////////////////////////////////
  // Arithmetic
  //////////////////////////////////////////////////////////////////////

  // Subtraction is an add with the sign bit flipped
  assign neg_a_pos.bits = {~smp_i.a_pos.bits[`MF_FP_W-1], smp_i.a_pos.bits[`MF_FP_W-2:0]};
  assign neg_b_pos.bits = {~smp_i.b_pos.bits[`MF_FP_W-1], smp_i.b_pos.bits[`MF_FP_W-2:0]};

  fp16_add u_add_alpha (
    .a_i   (smp_i.a_acc),
    .b_i   (neg_a_pos),
    .sum_o (alpha)
  );

  fp16_add u_add_beta (
    .a_i   (smp_i.b_acc),
    .b_i   (neg_b_pos),
    .sum_o (beta)
  );

  fp16_mul u_mul_scale (
    .a_i    (alpha),
    .b_i    (smp_i.s),
    .prod_o (alpha_scaled)
  );

  //////////////////////////////////////////////////////////////////////
  // Exponent binning
  //////////////////////////////////////////////////////////////////////

  assign exp_ofs = smp_i.s.f.exp - 5'(`MF_BIN_EXP_BASE);

  // Negative, zero and small values share bin 0, large ones pile into the top bin
  always_comb begin
    if (smp_i.s.f.sign || smp_i.s.f.exp <= 5'(`MF_BIN_EXP_BASE)) begin
      bin_idx = '0;
    end else if (exp_ofs > 5'(`MF_BINS - 1)) begin
      bin_idx = '1;
    end else begin
      bin_idx = exp_ofs[IDX_W-1:0];
    end
  end

  assign bin_hot = {{(`MF_BINS-1){1'b0}}, 1'b1} << bin_idx;

  // Result held until the next valid sample
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      res_valid_o <= 1'b0;
      res_o       <= '0;
    end else begin
      res_valid_o <= valid_i;
      if (valid_i) begin
        res_o <= '{alpha: alpha, alpha_scaled: alpha_scaled, beta: beta, bin: bin_hot};
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/modefind_hist.sv
`default_nettype none
`include "modefind_consts.svh"

module modefind_hist (
  input  logic                                clk,
  input  logic                                rst,
  input  modefind_pkg::lane_res_t             res0_i,
  input  modefind_pkg::lane_res_t             res1_i,
  input  logic                                res_valid_i,
  input  logic [`MF_CNT_W-1:0]                j_size_i,
  output logic [`MF_BINS-1:0][`MF_CNT_W-1:0]  bin_cnt_o,
  output modefind_pkg::hist_stat_t            stat_o
);

  localparam int CNT_W = `MF_CNT_W;
  localparam int IDX_W = $clog2(`MF_BINS);
  localparam logic [CNT_W-1:0] CNT_MAX = '1;

  logic [`MF_BINS-1:0][CNT_W-1:0] cnt_nxt;
  logic [IDX_W-1:0]               idx0;
  logic [IDX_W-1:0]               idx1;
  logic [CNT_W-1:0]               hit0_cnt;
  logic [CNT_W-1:0]               hit1_cnt;
  logic [IDX_W-1:0]               mode_bin_q;
  logic [IDX_W-1:0]               mode_bin_nxt;
  logic [CNT_W-1:0]               mode_cnt_q;
  logic [CNT_W-1:0]               mode_cnt_nxt;
  logic [CNT_W-1:0]               smp_cnt;

  function automatic logic [IDX_W-1:0] hot_to_idx(input logic [`MF_BINS-1:0] hot);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < `MF_BINS; i++) begin
      if (hot[i]) begin
        idx = IDX_W'(i);
      end
    end
    return idx;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bin counters and mode tracking
  //////////////////////////////////////////////////////////////////////

  // A bin hit by both lanes gains two, counters wrap
  always_comb begin
    for (int b = 0; b < `MF_BINS; b++) begin
      cnt_nxt[b] = bin_cnt_o[b] + CNT_W'(res0_i.bin[b]) + CNT_W'(res1_i.bin[b]);
    end
  end

  assign idx0     = hot_to_idx(res0_i.bin);
  assign idx1     = hot_to_idx(res1_i.bin);
  assign hit0_cnt = cnt_nxt[idx0];
  assign hit1_cnt = cnt_nxt[idx1];

  // Larger updated count wins, lane 0 on a tie
  always_comb begin
    mode_bin_nxt = mode_bin_q;
    mode_cnt_nxt = mode_cnt_q;
    if (hit0_cnt > mode_cnt_q && hit0_cnt >= hit1_cnt) begin
      mode_bin_nxt = idx0;
      mode_cnt_nxt = hit0_cnt;
    end else if (hit1_cnt > mode_cnt_q) begin
      mode_bin_nxt = idx1;
      mode_cnt_nxt = hit1_cnt;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bin_cnt_o  <= '0;
      mode_bin_q <= '0;
      mode_cnt_q <= '0;
      smp_cnt    <= '0;
    end else if (res_valid_i) begin
      bin_cnt_o  <= cnt_nxt;
      mode_bin_q <= mode_bin_nxt;
      mode_cnt_q <= mode_cnt_nxt;
      // Two samples per cycle, stuck at the top
      if (smp_cnt >= CNT_MAX - CNT_W'(1)) begin
        smp_cnt <= CNT_MAX;
      end else begin
        smp_cnt <= smp_cnt + CNT_W'(2);
      end
    end
  end

  assign stat_o = '{mode_bin: mode_bin_q, mode_cnt: mode_cnt_q, finished: (smp_cnt >= j_size_i)};

endmodule

`default_nettype wire

// File: hdl/modefind_top.sv
`default_nettype none
`include "modefind_consts.svh"

module modefind_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                valid_i,
  input  modefind_pkg::lane_in_t              lane0_i,
  input  modefind_pkg::lane_in_t              lane1_i,
  input  logic [`MF_CNT_W-1:0]                j_size_i,
  output modefind_pkg::lane_res_t             res0_o,
  output modefind_pkg::lane_res_t             res1_o,
  output logic                                result_valid_o,
  output logic [`MF_BINS-1:0][`MF_CNT_W-1:0]  bin_cnt_o,
  output modefind_pkg::hist_stat_t            stat_o
);

  // Both lanes share the strobe, lane 0 carries the valid level
  modefind_lane u_lane0 (
    .clk         (clk),
    .rst         (rst),
    .valid_i     (valid_i),
    .smp_i       (lane0_i),
    .res_o       (res0_o),
    .res_valid_o (result_valid_o)
  );

  modefind_lane u_lane1 (
    .clk         (clk),
    .rst         (rst),
    .valid_i     (valid_i),
    .smp_i       (lane1_i),
    .res_o       (res1_o),
    .res_valid_o ()
  );

  modefind_hist u_hist (
    .clk         (clk),
    .rst         (rst),
    .res0_i      (res0_o),
    .res1_i      (res1_o),
    .res_valid_i (result_valid_o),
    .j_size_i    (j_size_i),
    .bin_cnt_o   (bin_cnt_o),
    .stat_o      (stat_o)
  );

endmodule

`default_nettype wire

// File: bench/modefind_props.sv
`default_nettype none
`include "modefind_consts.svh"

module modefind_props (
  input logic                               clk,
  input logic                               rst,
  input logic                               valid_i,
  input logic                               result_valid_i,
  input modefind_pkg::lane_res_t            res0_i,
  input modefind_pkg::lane_res_t            res1_i,
  input logic [`MF_BINS-1:0][`MF_CNT_W-1:0] bin_cnt_i,
  input modefind_pkg::hist_stat_t           stat_i
);

  // Read by the testbench summary
  int prop_fail_cnt = 0;

  //////////////////////////////////////////////////////////////////////
  // Timing and counter invariants
  //////////////////////////////////////////////////////////////////////

  // Lane latency is one cycle
  a_valid_delay: assert property (@(posedge clk) disable iff (rst)
    result_valid_i == $past(valid_i))
    else begin
      $error("result_valid_o is not valid_i delayed by one cycle");
      prop_fail_cnt++;
    end

  a_mode_cnt_rise: assert property (@(posedge clk) disable iff (rst)
    stat_i.mode_cnt >= $past(stat_i.mode_cnt))
    else begin
      $error("mode_cnt decreased without a reset");
      prop_fail_cnt++;
    end

  a_finished_hold: assert property (@(posedge clk) disable iff (rst)
    $past(stat_i.finished) |-> stat_i.finished)
    else begin
      $error("finished fell without a reset");
      prop_fail_cnt++;
    end

  // First cycle out of reset
  a_reset_clean: assert property (@(posedge clk)
    $fell(rst) |-> !result_valid_i && res0_i == '0 && res1_i == '0 &&
                   bin_cnt_i == '0 && stat_i == '0)
    else begin
      $error("outputs are not cleared after reset");
      prop_fail_cnt++;
    end

endmodule

`default_nettype wire

// File: bench/modefind_tb.sv
`default_nettype none
`include "modefind_consts.svh"

module modefind_tb;

  localparam int CLK_PERIOD = 40;
  localparam int N_RAND     = 24;
  // Reset, subtraction, bin sweep, random burst, mode cycle, finished run
  localparam int RUN_CYCLES = 4 + 2 + 6 * 3 + (N_RAND + 3) + 3 + 20;
  localparam int MARGIN     = 50;

  logic                               clk;
  logic                               rst;
  logic                               valid_i;
  modefind_pkg::lane_in_t             lane0_i;
  modefind_pkg::lane_in_t             lane1_i;
  logic [`MF_CNT_W-1:0]               j_size_i;
  modefind_pkg::lane_res_t            res0_o;
  modefind_pkg::lane_res_t            res1_o;
  logic                               result_valid_o;
  logic [`MF_BINS-1:0][`MF_CNT_W-1:0] bin_cnt_o;
  modefind_pkg::hist_stat_t           stat_o;

  logic [31:0]          lfsr;
  logic [`MF_CNT_W-1:0] tally [`MF_BINS];
  int                   mode_bin_exp;
  logic [`MF_CNT_W-1:0] mode_cnt_exp;
  string                cur_test;
  int                   fail_cnt;
  int                   test_fail_base;
  int                   tests_run;
  int                   tests_failed;
  int                   total_fails;

  modefind_top uut (
    .clk            (clk),
    .rst            (rst),
    .valid_i        (valid_i),
    .lane0_i        (lane0_i),
    .lane1_i        (lane1_i),
    .j_size_i       (j_size_i),
    .res0_o         (res0_o),
    .res1_o         (res1_o),
    .result_valid_o (result_valid_o),
    .bin_cnt_o      (bin_cnt_o),
    .stat_o         (stat_o)
  );

  bind modefind_top modefind_props u_props (
    .clk            (clk),
    .rst            (rst),
    .valid_i        (valid_i),
    .result_valid_i (result_valid_o),
    .res0_i         (res0_o),
    .res1_i         (res1_o),
    .bin_cnt_i      (bin_cnt_o),
    .stat_i         (stat_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[14:0], fb};
    end
    return r;
  endfunction

  // Exponent minus 13 clamped to 0..7 with non-positive values in bin 0
  function automatic int bin_index(input logic [15:0] s);
    int e;
    e = int'(s[14:10]) - 13;
    if (s[15] || e < 0) begin
      return 0;
    end
    return (e > 7) ? 7 : e;
  endfunction

  // Fixed operands give alpha 6 minus 2 and beta 1 minus 3
  function automatic modefind_pkg::lane_in_t make_lane(input logic [15:0] s);
    modefind_pkg::lane_in_t l;
    l.s.bits     = s;
    l.a_acc.bits = 16'h4600;
    l.a_pos.bits = 16'h4000;
    l.b_acc.bits = 16'h3c00;
    l.b_pos.bits = 16'h4200;
    return l;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      fail_cnt++;
    end
  endtask

  task automatic open_test(input string name);
    cur_test       = name;
    test_fail_base = fail_cnt;
  endtask

  task automatic close_test();
    tests_run++;
    if (fail_cnt != test_fail_base) begin
      tests_failed++;
    end
    $display("test %s finished, %0d check(s) failed", cur_test, fail_cnt - test_fail_base);
  endtask

  // Histogram model with the mode update where lane 0 wins a tie
  task automatic tally_add(input int i0, input int i1);
    logic [`MF_CNT_W-1:0] c0;
    logic [`MF_CNT_W-1:0] c1;
    tally[i0] = tally[i0] + 1'b1;
    tally[i1] = tally[i1] + 1'b1;
    c0 = tally[i0];
    c1 = tally[i1];
    if (c0 > mode_cnt_exp && c0 >= c1) begin
      mode_bin_exp = i0;
      mode_cnt_exp = c0;
    end else if (c1 > mode_cnt_exp) begin
      mode_bin_exp = i1;
      mode_cnt_exp = c1;
    end
  endtask

  task automatic drive(input modefind_pkg::lane_in_t l0, input modefind_pkg::lane_in_t l1);
    @(posedge clk);
    valid_i <= 1'b1;
    lane0_i <= l0;
    lane1_i <= l1;
    tally_add(bin_index(l0.s.bits), bin_index(l1.s.bits));
  endtask

  // Lane result after the first edge and histogram after the second
  task automatic drain();
    @(posedge clk);
    valid_i <= 1'b0;
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic reset_dut(input logic [`MF_CNT_W-1:0] j_size);
    @(posedge clk);
    rst      <= 1'b1;
    j_size_i <= j_size;
    for (int b = 0; b < `MF_BINS; b++) begin
      tally[b] = '0;
    end
    mode_bin_exp = 0;
    mode_cnt_exp = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic subtract_scale();
    open_test("subtract_scale");
    drive(make_lane(16'h3800), make_lane(16'h0000));
    // Lane results one cycle after the strobe
    @(posedge clk);
    valid_i <= 1'b0;
    @(negedge clk);
    check_val("alpha0", 16'h4400, res0_o.alpha.bits);
    check_val("beta0", 16'hc000, res0_o.beta.bits);
    check_val("alpha_scaled0", 16'h4000, res0_o.alpha_scaled.bits);
    check_val("alpha1", 16'h4400, res1_o.alpha.bits);
    check_val("beta1", 16'hc000, res1_o.beta.bits);
    check_val("alpha_scaled1", 16'h0000, res1_o.alpha_scaled.bits);
    close_test();
  endtask

  task automatic bin_sweep();
    int          sweep_exp [10];
    logic [15:0] sweep_s [12];
    open_test("bin_sweep");
    // Below bin 0, each bin in turn, above bin 7
    sweep_exp = '{5, 13, 14, 15, 16, 17, 18, 19, 20, 26};
    for (int i = 0; i < 10; i++) begin
      sweep_s[i] = {1'b0, 5'(sweep_exp[i]), 10'h2a5};
    end
    sweep_s[10] = 16'hc400;
    sweep_s[11] = 16'h0000;
    for (int k = 0; k < 12; k += 2) begin
      drive(make_lane(sweep_s[k]), make_lane(sweep_s[k + 1]));
      drain();
      check_val("bin0", 8'b1 << bin_index(sweep_s[k]), res0_o.bin);
      check_val("bin1", 8'b1 << bin_index(sweep_s[k + 1]), res1_o.bin);
    end
    close_test();
  endtask

  task automatic histogram_run();
    logic [15:0] e;
    logic [15:0] m;
    logic [15:0] s0;
    logic [15:0] s1;
    open_test("histogram");
    for (int i = 0; i < N_RAND; i++) begin
      e  = rand_bits(3);
      m  = rand_bits(10);
      s0 = {1'b0, 5'(e + 16'd12), m[9:0]};
      e  = rand_bits(3);
      m  = rand_bits(10);
      s1 = (i % 5 == 0) ? s0 : {1'b0, 5'(e + 16'd12), m[9:0]};
      drive(make_lane(s0), make_lane(s1));
    end
    drain();
    for (int b = 0; b < `MF_BINS; b++) begin
      check_val($sformatf("bin_cnt[%0d]", b), tally[b], bin_cnt_o[b]);
    end
    close_test();
  endtask

  task automatic mode_check();
    open_test("mode");
    // Both lanes land in bin 3
    drive(make_lane(16'h4000), make_lane(16'h4000));
    drain();
    check_val("bin_cnt[3]", tally[3], bin_cnt_o[3]);
    check_val("mode_bin", mode_bin_exp, stat_o.mode_bin);
    check_val("mode_cnt", mode_cnt_exp, stat_o.mode_cnt);
    close_test();
  endtask

  task automatic finish_level();
    open_test("finished");
    reset_dut(8'd6);
    @(negedge clk);
    check_val("mode_cnt after reset", 0, stat_o.mode_cnt);
    drive(make_lane(16'h3c00), make_lane(16'h3c00));
    drive(make_lane(16'h3c00), make_lane(16'h3c00));
    drain();
    check_val("finished after 2", 1'b0, stat_o.finished);
    drive(make_lane(16'h3c00), make_lane(16'h3c00));
    drain();
    check_val("finished after 3", 1'b1, stat_o.finished);
    repeat (4) begin
      @(negedge clk);
      check_val("finished held", 1'b1, stat_o.finished);
    end
    drive(make_lane(16'h3c00), make_lane(16'h3c00));
    drain();
    check_val("finished after 4", 1'b1, stat_o.finished);
    close_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    valid_i      = 1'b0;
    lane0_i      = '0;
    lane1_i      = '0;
    j_size_i     = 8'd255;
    lfsr         = 32'he9c2_3e35;
    mode_bin_exp = 0;
    mode_cnt_exp = '0;
    fail_cnt     = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int b = 0; b < `MF_BINS; b++) begin
      tally[b] = '0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    subtract_scale();
    bin_sweep();
    histogram_run();
    mode_check();
    finish_level();
    total_fails = fail_cnt + uut.u_props.prop_fail_cnt;
    $display("%0d tests, %0d failed, %0d value checks failed, %0d property failures",
             tests_run, tests_failed, fail_cnt, uut.u_props.prop_fail_cnt);
    if (total_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #((RUN_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: modefind.f
+incdir+hdl
hdl/modefind_pkg.sv
hdl/fp16_add.sv
hdl/fp16_mul.sv
hdl/modefind_lane.sv
hdl/modefind_hist.sv
hdl/modefind_top.sv
bench/modefind_props.sv
bench/modefind_tb.sv
